/* logic/io_pkg.sv */
package io_pkg;

	//////////////////////////////
	// Bus and address widths
	//////////////////////////////

	localparam int DATA_W = 8; // Processor data width.
	localparam int UNIT_W = 3; // Unit index in adr[5:3].
	localparam int REG_W = 3; // Register index in adr[2:0].
	localparam int ADR_W = UNIT_W + REG_W;

	// Units 0 to NUM_PORTS-1 are GPIO ports, the last index is the interrupt unit.
	localparam logic [UNIT_W-1:0] IRQ_UNIT = 3'd7;

	//////////////////////////////
	// Register selects
	//////////////////////////////

	typedef enum logic [REG_W-1:0] {
		REG_DDR = 3'd0, // Direction, irq enable in the interrupt unit.
		REG_ODR = 3'd1, // Output, irq pending in the interrupt unit.
		REG_IDR = 3'd2, // Synchronized input.
		REG_EMR = 3'd3 // Rising edge mask.
	} reg_sel_e;

	//////////////////////////////
	// Bus slave states
	//////////////////////////////

	typedef enum logic {
		WB_IDLE = 1'b0,
		WB_ACK = 1'b1
	} wb_state_e;

endpackage

/* logic/wb_io_decoder.sv */
`timescale 1ns/1ps

module wb_io_decoder
	import io_pkg::*;
#(
	parameter int NUM_PORTS = 4
)
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADR_W-1:0] adr,
	output logic ack,
	output logic [NUM_PORTS-1:0] port_wr,
	output logic irq_wr,
	output logic rd_take,
	output logic [UNIT_W-1:0] acc_unit,
	output reg_sel_e acc_reg
);

	wb_state_e state;
	wb_state_e state_next;
	logic accept;
	logic wr_req;

	// Requests are only taken in idle, so every access is two cycles.
	assign accept = (state == WB_IDLE) && cyc && stb;
	assign wr_req = accept && we;

	assign acc_unit = adr[ADR_W-1:REG_W]; // Unit field.
	assign acc_reg = reg_sel_e'(adr[REG_W-1:0]); // Register field, may be unmapped.

	//////////////////////////////
	// Handshake FSM
	//////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			WB_IDLE:
			begin
				if (accept)
					state_next = WB_ACK;
			end
			WB_ACK:
			begin
				state_next = WB_IDLE; // Ack lasts exactly one cycle.
			end
			default:
			begin
				state_next = WB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= WB_IDLE;
		else
			state <= state_next;
	end

	assign ack = (state == WB_ACK); // Registered through the state flop.

	//////////////////////////////
	// Access strobes
	//////////////////////////////

	for (genvar k = 0; k < NUM_PORTS; k++)
	begin : g_port_wr
		assign port_wr[k] = wr_req && (acc_unit == UNIT_W'(k)); // One-hot by unit.
	end

	// Writes to units without a port or the irq unit get no strobe at all.
	assign irq_wr = wr_req && (acc_unit == IRQ_UNIT);
	assign rd_take = accept && !we; // Collector latches dat_r.

endmodule

/* logic/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port
	import io_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic wr,
	input reg_sel_e acc_reg,
	input logic [DATA_W-1:0] acc_data,
	input logic [DATA_W-1:0] pin_in,
	output logic [DATA_W-1:0] pin_out,
	output logic [DATA_W-1:0] pin_oe,
	output logic [DATA_W-1:0] rd_data,
	output logic edge_event
);

	logic [DATA_W-1:0] ddr;
	logic [DATA_W-1:0] odr;
	logic [DATA_W-1:0] emr;
	logic [DATA_W-1:0] sync_q; // First synchronizer stage.
	logic [DATA_W-1:0] idr; // Second stage, visible to software.
	logic [DATA_W-1:0] idr_prev;
	logic [DATA_W-1:0] rise;
	logic edge_q;

	//////////////////////////////
	// Software registers
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ddr <= '0;
			odr <= '0;
			emr <= '0;
		end
		else if (wr)
		begin
			case (acc_reg)
				REG_DDR: ddr <= acc_data;
				REG_ODR: odr <= acc_data;
				REG_EMR: emr <= acc_data;
				default: ; // IDR is read-only.
			endcase
		end
	end

	assign pin_out = odr;
	assign pin_oe = ddr; // 1 drives the pin.

	//////////////////////////////
	// Input path and edge detect
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sync_q <= '0;
			idr <= '0;
			idr_prev <= '0;
			edge_q <= 1'b0;
		end
		else
		begin
			sync_q <= pin_in;
			idr <= sync_q;
			idr_prev <= idr;
			edge_q <= |(rise & emr); // Only masked bits count.
		end
	end

	assign rise = idr & ~idr_prev;
	assign edge_event = edge_q; // Single cycle per rising edge.

	// Read-back for whatever register the current access selects.
	always_comb
	begin
		case (acc_reg)
			REG_DDR: rd_data = ddr;
			REG_ODR: rd_data = odr;
			REG_IDR: rd_data = idr;
			REG_EMR: rd_data = emr;
			default: rd_data = '0;
		endcase
	end

endmodule

/* logic/irq_read_collector.sv */
`timescale 1ns/1ps

module irq_read_collector
	import io_pkg::*;
#(
	parameter int NUM_PORTS = 4
)
(
	input logic clk,
	input logic arst_n,
	input logic irq_wr,
	input logic rd_take,
	input logic [UNIT_W-1:0] acc_unit,
	input reg_sel_e acc_reg,
	input logic [DATA_W-1:0] acc_data,
	input logic [NUM_PORTS*DATA_W-1:0] port_rd,
	input logic [NUM_PORTS-1:0] edge_event,
	output logic [DATA_W-1:0] dat_r,
	output logic irq
);

	logic [NUM_PORTS-1:0] irq_enable;
	logic [NUM_PORTS-1:0] irq_pending;
	logic [NUM_PORTS-1:0] enable_next;
	logic [NUM_PORTS-1:0] pending_next;
	logic [NUM_PORTS-1:0] clr_mask;
	logic [DATA_W-1:0] rd_mux;

	//////////////////////////////
	// Interrupt controller
	//////////////////////////////

	always_comb
	begin
		enable_next = irq_enable;
		clr_mask = '0;
		if (irq_wr && (acc_reg == REG_DDR))
			enable_next = acc_data[NUM_PORTS-1:0];
		if (irq_wr && (acc_reg == REG_ODR))
			clr_mask = acc_data[NUM_PORTS-1:0]; // Write 1 to clear.
		pending_next = (irq_pending & ~clr_mask) | edge_event; // New edge wins.
	end

	// irq follows the next pending state so it drops with the clear.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			irq_enable <= '0;
			irq_pending <= '0;
			irq <= 1'b0;
		end
		else
		begin
			irq_enable <= enable_next;
			irq_pending <= pending_next;
			irq <= |(pending_next & enable_next);
		end
	end

	//////////////////////////////
	// Read data
	//////////////////////////////

	always_comb
	begin
		rd_mux = '0; // Unmapped units and registers.
		for (int k = 0; k < NUM_PORTS; k++)
		begin
			if (acc_unit == UNIT_W'(k))
				rd_mux = port_rd[k*DATA_W +: DATA_W];
		end
		if (acc_unit == IRQ_UNIT)
		begin
			case (acc_reg)
				REG_DDR: rd_mux = DATA_W'(irq_enable);
				REG_ODR: rd_mux = DATA_W'(irq_pending);
				default: rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			dat_r <= '0;
		else if (rd_take)
			dat_r <= rd_mux; // Held while ack is high.
	end

endmodule

/* logic/io_subsystem.sv */
`timescale 1ns/1ps

module io_subsystem
	import io_pkg::*;
#(
	parameter int NUM_PORTS = 4 // 1 to 7, unit 7 is the irq unit.
)
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADR_W-1:0] adr,
	input logic [DATA_W-1:0] dat_w,
	output logic [DATA_W-1:0] dat_r,
	output logic ack,
	input logic [NUM_PORTS*DATA_W-1:0] pin_in,
	output logic [NUM_PORTS*DATA_W-1:0] pin_out,
	output logic [NUM_PORTS*DATA_W-1:0] pin_oe,
	output logic irq
);

	logic [NUM_PORTS-1:0] port_wr;
	logic irq_wr;
	logic rd_take;
	logic [UNIT_W-1:0] acc_unit;
	reg_sel_e acc_reg;
	logic [NUM_PORTS*DATA_W-1:0] port_rd;
	logic [NUM_PORTS-1:0] edge_event;

	wb_io_decoder #(.NUM_PORTS(NUM_PORTS)) u_decoder (
		.clk(clk),
		.arst_n(arst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.ack(ack),
		.port_wr(port_wr),
		.irq_wr(irq_wr),
		.rd_take(rd_take),
		.acc_unit(acc_unit),
		.acc_reg(acc_reg)
	);

	// Port k owns slice k of every pin and read-back vector.
	for (genvar k = 0; k < NUM_PORTS; k++)
	begin : g_port
		gpio_port u_port (
			.clk(clk),
			.arst_n(arst_n),
			.wr(port_wr[k]),
			.acc_reg(acc_reg),
			.acc_data(dat_w),
			.pin_in(pin_in[k*DATA_W +: DATA_W]),
			.pin_out(pin_out[k*DATA_W +: DATA_W]),
			.pin_oe(pin_oe[k*DATA_W +: DATA_W]),
			.rd_data(port_rd[k*DATA_W +: DATA_W]),
			.edge_event(edge_event[k])
		);
	end

	irq_read_collector #(.NUM_PORTS(NUM_PORTS)) u_collector (
		.clk(clk),
		.arst_n(arst_n),
		.irq_wr(irq_wr),
		.rd_take(rd_take),
		.acc_unit(acc_unit),
		.acc_reg(acc_reg),
		.acc_data(dat_w),
		.port_rd(port_rd),
		.edge_event(edge_event),
		.dat_r(dat_r),
		.irq(irq)
	);

endmodule

/* sim/io_subsystem_assert.sv */
`timescale 1ns/1ps

module io_subsystem_assert
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic ack
);

	// Ack answers a request from the previous cycle.
	ack_after_request: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> $past(cyc && stb))
		else $error("ack without a request in the previous cycle");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		ack |=> !ack)
		else $error("ack high for two cycles in a row");

	ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
		else $error("ack high during reset");

endmodule

bind wb_io_decoder io_subsystem_assert u_assert (
	.clk(clk),
	.arst_n(arst_n),
	.cyc(cyc),
	.stb(stb),
	.ack(ack)
);

/* sim/io_subsystem_tb.sv */
`timescale 1ns/1ps

module io_subsystem_tb
	import io_pkg::*;
();

	localparam int PORTS = 4;
	localparam int ACK_WAIT = 8; // Cycles before a missing ack is reported.
	localparam int CYCLES_PER_LINE = 20;

	logic clk = 1'b0;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [ADR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;
	logic [DATA_W-1:0] dat_r;
	logic ack;
	logic [PORTS*DATA_W-1:0] pin_in;
	logic [PORTS*DATA_W-1:0] pin_out;
	logic [PORTS*DATA_W-1:0] pin_oe;
	logic irq;

	byte ops[$];
	logic [7:0] addrs[$];
	logic [7:0] datas[$];
	logic [7:0] exps[$];
	int n_tests;
	int passes;
	int fails;
	bit loaded;

	io_subsystem #(.NUM_PORTS(PORTS)) dut (
		.clk(clk),
		.arst_n(arst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.pin_in(pin_in),
		.pin_out(pin_out),
		.pin_oe(pin_oe),
		.irq(irq)
	);

	always #50 clk = ~clk; // 100 ns period.

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual === expected)
		begin
			passes++;
			$display("PASS %s value %h", name, actual);
		end
		else
		begin
			fails++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_irq(input string name, input logic expected, input logic actual);
		if (actual === expected)
		begin
			passes++;
			$display("PASS %s irq %b", name, actual);
		end
		else
		begin
			fails++;
			$display("FAIL %s expected %b actual %b", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// Bus and pin drivers
	//////////////////////////////

	task automatic bus_access(input string name, input logic write, input logic [7:0] a,
			input logic [7:0] d, output logic [DATA_W-1:0] rdata, output bit got);
		got = 1'b0;
		rdata = '0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a[ADR_W-1:0];
		dat_w = d;
		for (int i = 0; i < ACK_WAIT && !got; i++)
		begin
			@(negedge clk);
			if (ack)
			begin
				got = 1'b1;
				rdata = dat_r; // Valid while ack is high.
				if (i != 0)
				begin
					fails++;
					$display("%s: ack came %0d cycles after the request instead of one",
						name, i + 1);
				end
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (!got)
		begin
			fails++;
			$display("%s: the DUT gave no ack within %0d cycles", name, ACK_WAIT);
		end
	endtask

	task automatic set_pins(input logic [7:0] port, input logic [7:0] value);
		int k;
		k = int'(port[2:0]);
		@(negedge clk);
		pin_in[k*DATA_W +: DATA_W] = value;
		repeat (4) @(negedge clk); // Two sync stages, edge flop, pending flop.
	endtask

	task automatic run_line(input int idx);
		string name;
		logic [DATA_W-1:0] rdata;
		bit got;
		int k;
		name = $sformatf("test %0d %c %h", idx + 1, ops[idx], addrs[idx]);
		k = int'(addrs[idx][2:0]);
		case (ops[idx])
			"W": bus_access(name, 1'b1, addrs[idx], datas[idx], rdata, got);
			"R":
			begin
				bus_access(name, 1'b0, addrs[idx], datas[idx], rdata, got);
				if (got)
					check_data(name, exps[idx], rdata);
			end
			"P": set_pins(addrs[idx], datas[idx]);
			"I": check_irq(name, exps[idx][0], irq);
			"O":
			begin
				if (datas[idx][0])
					check_data(name, exps[idx], pin_oe[k*DATA_W +: DATA_W]);
				else
					check_data(name, exps[idx], pin_out[k*DATA_W +: DATA_W]);
			end
			default:
			begin
				fails++;
				$display("%s: unknown opcode in the stimulus file", name);
			end
		endcase
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		logic [7:0] a;
		logic [7:0] d;
		logic [7:0] e;
		fd = $fopen("sim/io_stimulus.txt", "r");
		if (fd == 0)
		begin
			fails++;
			$display("Cannot open the stimulus file sim/io_stimulus.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#")
				begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
					if (n == 3)
					begin
						ops.push_back(line[0]);
						addrs.push_back(a);
						datas.push_back(d);
						exps.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
		n_tests = ops.size();
	endtask

	//////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////

	initial
	begin
		wait (loaded);
		repeat (n_tests * CYCLES_PER_LINE + 8) @(posedge clk);
		$display("Watchdog expired, the test sequence did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		pin_in = '0;
		passes = 0;
		fails = 0;
		loaded = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < n_tests; i++)
			run_line(i);
		$display("Tests: %0d passed, %0d failed", passes, fails);
		if (fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sim/io_stimulus.txt */
# op addr data expect, hex. W write, R read, P pins (addr = port), I irq,
# O pins (addr = port, data 0 = pin_out, 1 = pin_oe). Address is unit*8 + register.
I 00 00 00
O 00 01 00
R 01 00 00
W 00 a5 00
W 01 3c 00
W 0b 81 00
R 00 00 a5
R 01 00 3c
R 0b 00 81
R 08 00 00
O 00 00 3c
O 00 01 a5
O 01 01 00
P 02 5a 00
R 12 00 5a
W 13 01 00
W 38 04 00
R 38 00 04
P 02 5b 00
I 00 00 01
R 39 00 04
W 39 04 00
I 00 00 00
R 39 00 00
P 02 5f 00
I 00 00 00
P 01 01 00
I 00 00 00
R 39 00 02
R 20 00 00
R 04 00 00
R 3a 00 00

/* compile.f */
logic/io_pkg.sv
logic/wb_io_decoder.sv
logic/gpio_port.sv
logic/irq_read_collector.sv
logic/io_subsystem.sv
sim/io_subsystem_assert.sv
sim/io_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= io_subsystem_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
